// ==== common/fpu_pkg.sv ====
`default_nettype none

package fpu_pkg;

    // ================================================
    // opcodes
    // ================================================

    typedef enum logic [4:0] {
        ADD = 5'd16,
        SUB = 5'd17,
        MUL = 5'd18,
        NOP = 5'd22,
        SLT = 5'd23
    } fp_op_e;

    // ================================================
    // word layout and arithmetic widths
    // ================================================

    localparam int FP_WIDTH   = 32;
    localparam int EXP_WIDTH  = 8;
    localparam int FRAC_WIDTH = 23;
    localparam int MANT_WIDTH = 25;   // carry bit, hidden one and fraction.
    localparam int PROD_WIDTH = 48;
    localparam int EXP_BIAS   = 127;

    // ================================================
    // flow control and pipeline
    // ================================================

    localparam int CREDIT_DEPTH = 4;
    localparam int PIPE_LATENCY = 3;
    localparam int PTR_WIDTH    = $clog2(CREDIT_DEPTH);
    localparam int CNT_WIDTH    = $clog2(CREDIT_DEPTH + 1);

    // an operand split into its fields, with the hidden one made explicit.
    typedef struct packed {
        logic                  sign;
        logic [EXP_WIDTH-1:0]  exp;
        logic [MANT_WIDTH-1:0] mant;
    } unpacked_t;

endpackage

`default_nettype wire

// ==== common/fp_stage_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface fp_stage_if import fpu_pkg::*; ();

    logic                  valid;
    fp_op_e                op;
    unpacked_t             operand_a;
    unpacked_t             operand_b;
    logic [FP_WIDTH-1:0]   raw_a;     // original word, or the decided result when shortcut is set.
    logic                  shortcut;
    logic [PROD_WIDTH-1:0] wide_mant;

    modport src (
        output valid, op, operand_a, operand_b, raw_a, shortcut, wide_mant
    );

    modport dst (
        input valid, op, operand_a, operand_b, raw_a, shortcut, wide_mant
    );

endinterface

`default_nettype wire

// ==== fp_pipe/fp_unpack_align.sv ====
`timescale 1ns/1ns
`default_nettype none

module fp_unpack_align import fpu_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue_valid,
    input  fp_op_e              issue_op,
    input  logic [FP_WIDTH-1:0] issue_a,
    input  logic [FP_WIDTH-1:0] issue_b,
    fp_stage_if.src             stage_out
);

    unpacked_t           ua;
    unpacked_t           ub;
    unpacked_t           aligned_a;
    unpacked_t           aligned_b;
    logic                a_zero;
    logic                b_zero;
    logic                short_hit;
    logic [FP_WIDTH-1:0] short_word;

    // split the words and put the hidden one back in front of the fraction.
    always_comb begin
        ua.sign = issue_a[FP_WIDTH-1];
        ua.exp  = issue_a[FP_WIDTH-2:FRAC_WIDTH];
        ua.mant = {2'b01, issue_a[FRAC_WIDTH-1:0]};
        ub.sign = issue_b[FP_WIDTH-1];
        ub.exp  = issue_b[FP_WIDTH-2:FRAC_WIDTH];
        ub.mant = {2'b01, issue_b[FRAC_WIDTH-1:0]};
    end

    assign a_zero = (issue_a[FP_WIDTH-2:0] == '0);   // either sign of zero counts.
    assign b_zero = (issue_b[FP_WIDTH-2:0] == '0);

    always_comb begin
        aligned_a  = ua;
        aligned_b  = ub;
        short_hit  = 1'b0;
        short_word = issue_a;
        case (issue_op)
            ADD, SUB: begin
                if (b_zero) begin
                    short_hit  = 1'b1;
                    short_word = issue_a;
                end else if (a_zero) begin
                    short_hit  = 1'b1;
                    short_word = issue_b;          // the second operand comes back unchanged.
                end else if (ua.exp > ub.exp) begin
                    aligned_b.mant = ub.mant >> (ua.exp - ub.exp);
                    aligned_b.exp  = ua.exp;
                end else begin
                    aligned_a.mant = ua.mant >> (ub.exp - ua.exp);
                    aligned_a.exp  = ub.exp;
                end
            end
            MUL: begin
                if (a_zero || b_zero) begin
                    short_hit  = 1'b1;
                    short_word = '0;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_out.valid <= 1'b0;
        end else begin
            stage_out.valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        stage_out.op        <= issue_op;
        stage_out.operand_a <= aligned_a;
        stage_out.operand_b <= aligned_b;
        stage_out.raw_a     <= short_word;
        stage_out.shortcut  <= short_hit;
        stage_out.wide_mant <= '0;   // the product only exists from stage two on.
    end

endmodule

`default_nettype wire

// ==== fp_pipe/fp_arith.sv ====
`timescale 1ns/1ns
`default_nettype none

module fp_arith import fpu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    fp_stage_if.dst stage_in,
    fp_stage_if.src stage_out
);

    unpacked_t             op_a;
    unpacked_t             op_b;
    unpacked_t             res;
    logic                  sign_b;
    logic                  a_lt_b;
    logic                  short_hit;
    logic [FP_WIDTH-1:0]   word;
    logic [PROD_WIDTH-1:0] prod;

    assign op_a = stage_in.operand_a;
    assign op_b = stage_in.operand_b;

    // ================================================
    // set-less-than on the unaligned operands
    // ================================================

    always_comb begin
        if (op_a.sign != op_b.sign) begin
            a_lt_b = op_a.sign;
        end else if (op_a.exp != op_b.exp) begin
            a_lt_b = (op_a.exp < op_b.exp) ^ op_a.sign;   // order flips for negatives.
        end else if (op_a.sign) begin
            a_lt_b = (op_a.mant > op_b.mant);
        end else begin
            a_lt_b = (op_a.mant < op_b.mant);
        end
    end

    // ================================================
    // add, subtract and multiply
    // ================================================

    always_comb begin
        sign_b = op_b.sign;
        if (stage_in.op == SUB) begin
            sign_b = ~op_b.sign;
        end
        res       = op_a;
        word      = stage_in.raw_a;
        short_hit = stage_in.shortcut;
        prod      = '0;
        case (stage_in.op)
            ADD, SUB: begin
                if (!stage_in.shortcut) begin
                    if (sign_b == op_a.sign) begin
                        res.mant = op_a.mant + op_b.mant;
                    end else if (op_a.mant >= op_b.mant) begin
                        res.mant = op_a.mant - op_b.mant;
                    end else begin
                        res.mant = op_b.mant - op_a.mant;
                        res.sign = sign_b;
                    end
                    // cancellation leaves nothing to normalize, so the word is settled here.
                    if (res.mant == '0) begin
                        short_hit = 1'b1;
                        word      = '0;
                    end
                end
            end
            MUL: begin
                if (!stage_in.shortcut) begin
                    prod     = op_a.mant[MANT_WIDTH-2:0] * op_b.mant[MANT_WIDTH-2:0];
                    res.sign = op_a.sign ^ op_b.sign;
                    res.exp  = op_a.exp + op_b.exp - EXP_WIDTH'(EXP_BIAS - 1);
                end
            end
            SLT: begin
                word = {{(FP_WIDTH-1){1'b0}}, a_lt_b};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_out.valid <= 1'b0;
        end else begin
            stage_out.valid <= stage_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        stage_out.op        <= stage_in.op;
        stage_out.operand_a <= res;
        stage_out.operand_b <= op_b;
        stage_out.raw_a     <= word;
        stage_out.shortcut  <= short_hit;
        stage_out.wide_mant <= prod;
    end

endmodule

`default_nettype wire

// ==== fp_pipe/fp_normalize.sv ====
`timescale 1ns/1ns
`default_nettype none

module fp_normalize import fpu_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    fp_stage_if.dst             stage_in,
    output logic                result_valid,
    output logic [FP_WIDTH-1:0] result
);

    logic [MANT_WIDTH-1:0] mant;
    logic [MANT_WIDTH-1:0] shifted;
    logic [4:0]            lead_shift;
    logic [EXP_WIDTH-1:0]  exp_n;
    logic [FRAC_WIDTH-1:0] frac;
    logic                  pass_word;
    logic [FP_WIDTH-1:0]   word;

    assign mant = stage_in.operand_a.mant;

    // leading-one search below the carry bit. the highest set bit wins.
    always_comb begin
        lead_shift = '0;
        for (int i = 0; i < MANT_WIDTH - 1; i++) begin
            if (mant[i]) begin
                lead_shift = 5'(MANT_WIDTH - 2 - i);
            end
        end
    end

    assign shifted = mant << lead_shift;

    always_comb begin
        exp_n = stage_in.operand_a.exp;
        frac  = mant[FRAC_WIDTH-1:0];
        case (stage_in.op)
            ADD, SUB: begin
                if (mant[MANT_WIDTH-1]) begin
                    frac  = mant[FRAC_WIDTH:1];   // a carry out moves the point one step right.
                    exp_n = stage_in.operand_a.exp + 1'b1;
                end else begin
                    frac  = shifted[FRAC_WIDTH-1:0];
                    exp_n = stage_in.operand_a.exp - EXP_WIDTH'(lead_shift);
                end
            end
            MUL: begin
                // the top 24 product bits hold the hidden one and the fraction.
                if (stage_in.wide_mant[PROD_WIDTH-1]) begin
                    frac = stage_in.wide_mant[PROD_WIDTH-2 -: FRAC_WIDTH];
                end else begin
                    frac  = stage_in.wide_mant[PROD_WIDTH-3 -: FRAC_WIDTH];
                    exp_n = stage_in.operand_a.exp - 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    assign pass_word = stage_in.shortcut || (stage_in.op == SLT) || (stage_in.op == NOP);

    always_comb begin
        if (pass_word) begin
            word = stage_in.raw_a;
        end else begin
            word = {stage_in.operand_a.sign, exp_n, frac};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= stage_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        result <= word;
    end

endmodule

`default_nettype wire

// ==== hdl/cmd_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module cmd_queue import fpu_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  fp_op_e              cmd_op,
    input  logic [FP_WIDTH-1:0] cmd_a,
    input  logic [FP_WIDTH-1:0] cmd_b,
    input  logic                result_credit,
    output logic                issue_valid,
    output fp_op_e              issue_op,
    output logic [FP_WIDTH-1:0] issue_a,
    output logic [FP_WIDTH-1:0] issue_b,
    output logic                cmd_credit
);

    fp_op_e               op_mem [CREDIT_DEPTH];
    logic [FP_WIDTH-1:0]  a_mem  [CREDIT_DEPTH];
    logic [FP_WIDTH-1:0]  b_mem  [CREDIT_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic [CNT_WIDTH-1:0] res_credits;

    // the head goes out only with a result slot reserved downstream.
    assign issue_valid = (count != '0) && (res_credits != '0);
    assign issue_op    = op_mem[rd_ptr];
    assign issue_a     = a_mem[rd_ptr];
    assign issue_b     = b_mem[rd_ptr];
    assign cmd_credit  = issue_valid;   // a freed slot goes straight back to the source.

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            op_mem[wr_ptr] <= cmd_op;
            a_mem[wr_ptr]  <= cmd_a;
            b_mem[wr_ptr]  <= cmd_b;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (issue_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cmd_valid, issue_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ================================================
    // result credits
    // ================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            res_credits <= CNT_WIDTH'(CREDIT_DEPTH);
        end else begin
            case ({issue_valid, result_credit})
                2'b10:   res_credits <= res_credits - 1'b1;
                2'b01:   res_credits <= res_credits + 1'b1;
                default: res_credits <= res_credits;   // both or neither cancel out.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fp_alu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fp_alu_top import fpu_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  fp_op_e              cmd_op,
    input  logic [FP_WIDTH-1:0] cmd_a,
    input  logic [FP_WIDTH-1:0] cmd_b,
    output logic                cmd_credit,
    output logic                result_valid,
    output logic [FP_WIDTH-1:0] result,
    input  logic                result_credit
);

    logic                issue_valid;
    fp_op_e              issue_op;
    logic [FP_WIDTH-1:0] issue_a;
    logic [FP_WIDTH-1:0] issue_b;

    fp_stage_if align_if ();
    fp_stage_if arith_if ();

    cmd_queue u_cmd_queue (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_a         (cmd_a),
        .cmd_b         (cmd_b),
        .result_credit (result_credit),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .cmd_credit    (cmd_credit)
    );

    // three registered stages with no stalls between them.
    fp_unpack_align u_unpack_align (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .stage_out   (align_if.src)
    );

    fp_arith u_arith (
        .clk       (clk),
        .reset     (reset),
        .stage_in  (align_if.dst),
        .stage_out (arith_if.src)
    );

    fp_normalize u_normalize (
        .clk          (clk),
        .reset        (reset),
        .stage_in     (arith_if.dst),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

// ==== testbench/fp_alu_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module fp_alu_props import fpu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic cmd_valid,
    input logic cmd_credit,
    input logic issue_valid,
    input logic result_valid,
    input logic result_credit
);

    int fail_count = 0;
    int cmds_open;      // commands sent whose credit has not come back.
    int results_held;   // results delivered and not yet credited by the sink.

    always_ff @(posedge clk) begin
        if (reset) begin
            cmds_open    <= 0;
            results_held <= 0;
        end else begin
            cmds_open    <= cmds_open + int'(cmd_valid) - int'(cmd_credit);
            results_held <= results_held + int'(result_valid) - int'(result_credit);
        end
    end

    latency_check: assert property (@(posedge clk) disable iff (reset)
        result_valid == $past(issue_valid, PIPE_LATENCY))
        else begin
            fail_count++;
            $error("result_valid does not trail issue_valid by the pipeline latency");
        end

    // the result must land in a slot the sink has granted.
    result_slot_check: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (results_held < CREDIT_DEPTH))
        else begin
            fail_count++;
            $error("result_valid while the sink holds no free credit");
        end

    cmd_credit_check: assert property (@(posedge clk) disable iff (reset)
        cmd_credit |-> (cmds_open != 0))
        else begin
            fail_count++;
            $error("cmd_credit returned without an accepted command");
        end

endmodule

`default_nettype wire

// ==== testbench/tb_fp_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fp_alu import fpu_pkg::*; ();

    localparam int RESET_CYCLES   = 16;
    localparam int STALL_CYCLES   = 40;
    localparam int N_NOP          = 12;
    localparam int N_ADD          = 24;
    localparam int N_SUB          = 24;
    localparam int N_MUL          = 24;
    localparam int N_SLT          = 24;
    localparam int N_STALL        = 12;
    localparam int TOTAL_CMDS     = N_NOP + N_ADD + N_SUB + N_MUL + N_SLT + N_STALL;
    localparam int TIMEOUT_CYCLES = TOTAL_CMDS * 40 + RESET_CYCLES;

    logic                clk;
    logic                reset;
    logic                cmd_valid;
    fp_op_e              cmd_op;
    logic [FP_WIDTH-1:0] cmd_a;
    logic [FP_WIDTH-1:0] cmd_b;
    logic                cmd_credit;
    logic                result_valid;
    logic [FP_WIDTH-1:0] result;
    logic                result_credit;

    logic [15:0]         lfsr_state;
    fp_op_e              send_op_q [$];
    logic [FP_WIDTH-1:0] send_a_q  [$];
    logic [FP_WIDTH-1:0] send_b_q  [$];
    logic [FP_WIDTH-1:0] score_q   [$];   // expected results in command order.
    int                  cmd_credits;
    int                  credits_owed;
    int                  credit_delay;
    int                  stall_left;
    int                  check_count;
    int                  error_count;
    int                  cycle_count;
    int                  total_errors;

    fp_alu_top u_dut (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_a         (cmd_a),
        .cmd_b         (cmd_b),
        .cmd_credit    (cmd_credit),
        .result_valid  (result_valid),
        .result        (result),
        .result_credit (result_credit)
    );

    bind fp_alu_top fp_alu_props u_props (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd_credit    (cmd_credit),
        .issue_valid   (issue_valid),
        .result_valid  (result_valid),
        .result_credit (result_credit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ================================================
    // random numbers and the reference model
    // ================================================

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // small integers encode exactly. the fraction is the magnitude below its top bit.
    function automatic logic [FP_WIDTH-1:0] to_float(input int v);
        int mag;
        int msb;
        if (v == 0) begin
            return '0;
        end
        mag = (v < 0) ? -v : v;
        msb = 0;
        for (int i = 0; i < 24; i++) begin
            if (mag >= (1 << i)) begin
                msb = i;
            end
        end
        return {v < 0, 8'(127 + msb), 23'((mag << (23 - msb)) & 32'h007F_FFFF)};
    endfunction

    function int draw_operand();
        int mag;
        if (take_bits(3) == 0) begin
            return 0;   // positive zero comes up in one draw out of eight.
        end
        mag = take_bits(8);
        if (mag == 0) begin
            mag = 1;
        end
        if (take_bits(1) == 1) begin
            mag = -mag;
        end
        return mag;
    endfunction

    task automatic build_test(input fp_op_e op, input int n);
        int                  a;
        int                  b;
        logic [FP_WIDTH-1:0] wa;
        logic [FP_WIDTH-1:0] wb;
        logic [FP_WIDTH-1:0] expected;
        for (int i = 0; i < n; i++) begin
            a = draw_operand();
            b = draw_operand();
            if (op == ADD && take_bits(2) == 0) begin
                b = -a;                    // exact cancellation.
            end
            if (op == SUB && take_bits(2) == 0) begin
                b = a;
            end
            wa = to_float(a);
            wb = to_float(b);
            case (op)
                ADD:     expected = to_float(a + b);
                SUB:     expected = (a == 0) ? wb : to_float(a - b);   // b comes back as is.
                MUL:     expected = to_float(a * b);
                SLT:     expected = (a < b) ? 32'd1 : 32'd0;
                default: begin
                    wa       = (32'(take_bits(16)) << 16) | 32'(take_bits(16));
                    expected = wa;
                end
            endcase
            send_op_q.push_back(op);
            send_a_q.push_back(wa);
            send_b_q.push_back(wb);
            score_q.push_back(expected);
        end
    endtask

    // ================================================
    // per-cycle source and sink
    // ================================================

    task automatic service_cycle();
        logic [FP_WIDTH-1:0] expected;
        if (result_valid) begin
            check_count++;
            credits_owed++;
            if (score_q.size() == 0) begin
                $display("a result came out at %0t with no command outstanding", $time);
                error_count++;
            end else begin
                expected = score_q.pop_front();
                assert (result == expected) else begin
                    $display("ERR %0t result got %08h expected %08h", $time, result, expected);
                    error_count++;
                end
            end
        end
        if (stall_left > 0) begin
            stall_left--;
            result_credit = 1'b0;
        end else if (credits_owed > 0 && credit_delay == 0) begin
            result_credit = 1'b1;
            credits_owed--;
            credit_delay = take_bits(2);
            if (take_bits(3) == 0) begin
                credit_delay += 8;         // an occasional long hold-off.
            end
        end else begin
            result_credit = 1'b0;
            if (credit_delay > 0) begin
                credit_delay--;
            end
        end
        if (cmd_credit) begin
            cmd_credits++;
        end
        if (cmd_credits > 0 && send_op_q.size() > 0) begin
            cmd_valid = 1'b1;
            cmd_op    = send_op_q.pop_front();
            cmd_a     = send_a_q.pop_front();
            cmd_b     = send_b_q.pop_front();
            cmd_credits--;
        end else begin
            cmd_valid = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input fp_op_e op, input int n,
                            input bit stall);
        int errors_before;
        errors_before = error_count;
        build_test(op, n);
        stall_left = stall ? STALL_CYCLES : 0;
        while (send_op_q.size() > 0 || score_q.size() > 0) begin
            @(negedge clk);
            service_cycle();
        end
        $display("test %-6s %0d commands, %0d mismatches", name, n, error_count - errors_before);
    endtask

    initial begin
        reset         = 1'b1;
        cmd_valid     = 1'b0;
        cmd_op        = NOP;
        cmd_a         = '0;
        cmd_b         = '0;
        result_credit = 1'b0;
        lfsr_state    = 16'd94;
        cmd_credits   = CREDIT_DEPTH;
        credits_owed  = 0;
        credit_delay  = 0;
        stall_left    = 0;
        check_count   = 0;
        error_count   = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        run_test("nop", NOP, N_NOP, 1'b0);
        run_test("add", ADD, N_ADD, 1'b0);
        run_test("sub", SUB, N_SUB, 1'b0);
        run_test("mul", MUL, N_MUL, 1'b0);
        run_test("slt", SLT, N_SLT, 1'b0);
        run_test("stall", MUL, N_STALL, 1'b1);
        total_errors = error_count + u_dut.u_props.fail_count;
        $display("results checked %0d, mismatches %0d, assertion failures %0d",
                 check_count, error_count, u_dut.u_props.fail_count);
        if (total_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d results never arrived",
                 cycle_count, score_q.size());
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
common/fpu_pkg.sv
common/fp_stage_if.sv
fp_pipe/fp_unpack_align.sv
fp_pipe/fp_arith.sv
fp_pipe/fp_normalize.sv
hdl/cmd_queue.sv
hdl/fp_alu_top.sv
testbench/fp_alu_props.sv
testbench/tb_fp_alu.sv

// ==== Makefile ====
# Verilator build and run for the floating-point pipeline testbench.

VERILATOR   ?= verilator
TOP         ?= tb_fp_alu
FILELIST    ?= build.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS      ?= --binary --timing --assert -Wno-fatal

SOURCES  := $(shell grep -v '^+' $(FILELIST))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
FAIL_MSG := Some tests failed

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1; \
	status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
